// File: include/ibuf_params.svh
`ifndef IBUF_PARAMS_SVH
`define IBUF_PARAMS_SVH

// Slots per fetch bundle, one 32-bit instruction each
`define IBUF_FETCH_WIDTH 4

// FIFO entries between fetch and decode
`define IBUF_FIFO_DEPTH 8

// Occupancy count width
`define IBUF_COUNT_W 6

// Bit range of the 128-bit cache line bundle
`define ICACHE_FETCHWIDTH128_RANGE 127:0

`endif

// File: verilog/ibuf_pkg.sv
`include "ibuf_params.svh"

package ibuf_pkg;

    typedef logic [31:0] instr_t;     // One RISC-V instruction word
    typedef logic [63:0] pc_t;        // Full fetch PC
    typedef logic [47:0] ib_pc_t;     // PC as seen by decode
    typedef logic [31:0] target_t;    // Predicted branch target

    // FIFO entry, from the MSB down:
    // predict-taken bit, target, instruction, full PC
    typedef logic [128:0] fifo_entry_t;

    // FIFO occupancy
    typedef logic [`IBUF_COUNT_W-1:0] count_t;

endpackage

// File: verilog/fifo_ibuffer.sv
`timescale 1ns/1ps
`include "ibuf_params.svh"

module fifo_ibuffer (
    input  logic                  clock,
    input  logic                  reset_n,
    input  ibuf_pkg::fifo_entry_t data_in,
    input  logic                  write_en,
    input  logic                  read_en,
    input  logic                  stall,
    input  logic                  redirect_valid,
    output ibuf_pkg::fifo_entry_t data_out,
    output logic                  data_valid,
    output logic                  empty,
    output logic                  full,
    output ibuf_pkg::count_t      count
);
    // Depth is a power of two, so the pointers wrap on their own
    localparam int PTR_W = $clog2(`IBUF_FIFO_DEPTH);

    ibuf_pkg::fifo_entry_t mem [`IBUF_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    assign empty = (count == '0);
    assign full  = (count == ibuf_pkg::count_t'(`IBUF_FIFO_DEPTH));

    assign push = write_en && !full;            // Write while full is dropped
    assign pop  = read_en && !empty && !stall;  // Stall blocks the read port

    // Entry storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (redirect_valid) begin
            // Flush on redirect
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together
            endcase
        end
    end

    // Registered read port with one valid pulse per pop
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            data_valid <= 1'b0;
        end else if (redirect_valid) begin
            data_valid <= 1'b0;
        end else if (!stall) begin
            data_valid <= pop;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            data_out <= mem[rd_ptr];  // Holds through a stall
        end
    end

    a_count_bound: assert property (
        @(posedge clock) disable iff (!reset_n)
        count <= ibuf_pkg::count_t'(`IBUF_FIFO_DEPTH)
    ) else $error("fifo_ibuffer count above depth");

    // Pointer distance matches the occupancy modulo the depth
    a_ptr_count: assert property (
        @(posedge clock) disable iff (!reset_n)
        (wr_ptr - rd_ptr) == count[PTR_W-1:0]
    ) else $error("fifo_ibuffer pointers disagree with count");

endmodule

// File: verilog/ibuffer.sv
`timescale 1ns/1ps
`include "ibuf_params.svh"

module ibuffer (
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  logic [`ICACHE_FETCHWIDTH128_RANGE]    admin2ib_instr,
    input  logic [`IBUF_FETCH_WIDTH-1:0]          admin2ib_instr_valid,
    input  ibuf_pkg::pc_t                         pc,
    input  logic [`IBUF_FETCH_WIDTH-1:0]          admin2ib_predicttaken,
    input  logic [`IBUF_FETCH_WIDTH*32-1:0]       admin2ib_predicttarget,
    input  logic                                  fifo_read_en,
    input  logic                                  mem_stall,
    input  logic                                  redirect_valid,
    output logic                                  ibuffer_instr_valid,
    output logic                                  ibuffer_predicttaken_out,
    output ibuf_pkg::target_t                     ibuffer_predicttarget_out,
    output ibuf_pkg::instr_t                      ibuffer_inst_out,
    output ibuf_pkg::ib_pc_t                      ibuffer_pc_out,
    output logic                                  fetch_inst,
    output logic                                  fifo_empty
);
    localparam int FW     = `IBUF_FETCH_WIDTH;
    localparam int IDX_W  = $clog2(FW);
    localparam int PEND_W = $clog2(FW + 1);

    ibuf_pkg::instr_t      inst_cut   [FW];
    ibuf_pkg::pc_t         pc_cut     [FW];
    ibuf_pkg::target_t     target_cut [FW];
    ibuf_pkg::fifo_entry_t slot_buf   [FW];  // Latched slots of the current bundle

    ibuf_pkg::fifo_entry_t fifo_data_out;
    ibuf_pkg::count_t      fifo_count;
    ibuf_pkg::count_t      fifo_count_prev;
    logic                  fifo_full;
    logic                  fifo_write_en;

    logic [PEND_W-1:0] slot_total;  // Valid slots in the incoming bundle
    logic [PEND_W-1:0] pend_cnt;    // Slots still to be written
    logic [IDX_W-1:0]  wr_idx;      // Next slot to write
    logic              bundle_in;

    assign bundle_in = (admin2ib_instr_valid != '0);

    // Cut the line into slots, slot PC is base plus 4 per slot
    always_comb begin
        for (int i = 0; i < FW; i++) begin
            inst_cut[i]   = admin2ib_instr[i*32 +: 32];
            target_cut[i] = admin2ib_predicttarget[i*32 +: 32];
            pc_cut[i]     = pc + ibuf_pkg::pc_t'(4 * i);
        end
    end

    always_comb begin
        slot_total = '0;
        for (int i = 0; i < FW; i++) begin
            slot_total = slot_total + PEND_W'(admin2ib_instr_valid[i]);
        end
    end

    // Slot registers, only valid slots are loaded
    always_ff @(posedge clock) begin
        for (int i = 0; i < FW; i++) begin
            if (admin2ib_instr_valid[i]) begin
                slot_buf[i] <= {admin2ib_predicttaken[i], target_cut[i],
                                inst_cut[i], pc_cut[i]};
            end
        end
    end

    // Feed the FIFO one slot per cycle while it has room
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pend_cnt <= '0;
            wr_idx   <= '0;
        end else if (redirect_valid) begin
            pend_cnt <= '0;
            wr_idx   <= '0;
        end else if (bundle_in) begin
            pend_cnt <= slot_total;
            wr_idx   <= '0;
        end else if (fifo_write_en && !fifo_full) begin
            pend_cnt <= pend_cnt - 1'b1;
            wr_idx   <= wr_idx + 1'b1;  // Wraps to 0 after the last slot
        end
    end

    assign fifo_write_en = (pend_cnt != '0);

    // Ask for the next bundle when empty or on the 4 to 3 step
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fetch_inst      <= 1'b1;
            fifo_count_prev <= '0;
        end else if (redirect_valid) begin
            fetch_inst      <= 1'b1;
            fifo_count_prev <= '0;
        end else begin
            fifo_count_prev <= fifo_count;
            fetch_inst      <= fifo_empty ||
                               (fifo_count_prev == ibuf_pkg::count_t'(4) &&
                                fifo_count == ibuf_pkg::count_t'(3));
        end
    end

    fifo_ibuffer u_fifo (
        .clock          (clock),
        .reset_n        (reset_n),
        .data_in        (slot_buf[wr_idx]),
        .write_en       (fifo_write_en),
        .read_en        (fifo_read_en),
        .stall          (mem_stall),
        .redirect_valid (redirect_valid),
        .data_out       (fifo_data_out),
        .data_valid     (ibuffer_instr_valid),
        .empty          (fifo_empty),
        .full           (fifo_full),
        .count          (fifo_count)
    );

    // Decode fields, PC is cut down to 48 bits
    assign ibuffer_predicttaken_out  = fifo_data_out[128];
    assign ibuffer_predicttarget_out = fifo_data_out[127:96];
    assign ibuffer_inst_out          = fifo_data_out[95:64];
    assign ibuffer_pc_out            = fifo_data_out[47:0];

    // A mask contiguous from slot 0 has no bit in common with itself plus one
    a_mask_contiguous: assert property (
        @(posedge clock) disable iff (!reset_n)
        (admin2ib_instr_valid & (admin2ib_instr_valid + 1'b1)) == '0
    ) else $error("ibuffer valid mask not contiguous from slot 0");

    a_no_overlap: assert property (
        @(posedge clock) disable iff (!reset_n)
        bundle_in |-> (pend_cnt == '0)
    ) else $error("ibuffer bundle arrived while slots still pending");

endmodule

// File: verilog/ifu_ibuffer_top.sv
`timescale 1ns/1ps
`include "ibuf_params.svh"

module ifu_ibuffer_top (
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  logic [`ICACHE_FETCHWIDTH128_RANGE]    admin2ib_instr,
    input  logic [`IBUF_FETCH_WIDTH-1:0]          admin2ib_instr_valid,
    input  ibuf_pkg::pc_t                         pc,
    input  logic [`IBUF_FETCH_WIDTH-1:0]          admin2ib_predicttaken,
    input  logic [`IBUF_FETCH_WIDTH*32-1:0]       admin2ib_predicttarget,
    input  logic                                  fifo_read_en,
    input  logic                                  mem_stall,
    input  logic                                  redirect_valid,
    output logic                                  ibuffer_instr_valid,
    output logic                                  ibuffer_predicttaken_out,
    output ibuf_pkg::target_t                     ibuffer_predicttarget_out,
    output ibuf_pkg::instr_t                      ibuffer_inst_out,
    output ibuf_pkg::ib_pc_t                      ibuffer_pc_out,
    output logic                                  fetch_inst,
    output logic                                  fifo_empty
);

    // Instruction buffer between fetch and decode
    ibuffer u_ibuffer (
        .clock                     (clock),
        .reset_n                   (reset_n),
        .admin2ib_instr            (admin2ib_instr),
        .admin2ib_instr_valid      (admin2ib_instr_valid),
        .pc                        (pc),
        .admin2ib_predicttaken     (admin2ib_predicttaken),
        .admin2ib_predicttarget    (admin2ib_predicttarget),
        .fifo_read_en              (fifo_read_en),
        .mem_stall                 (mem_stall),
        .redirect_valid            (redirect_valid),
        .ibuffer_instr_valid       (ibuffer_instr_valid),
        .ibuffer_predicttaken_out  (ibuffer_predicttaken_out),
        .ibuffer_predicttarget_out (ibuffer_predicttarget_out),
        .ibuffer_inst_out          (ibuffer_inst_out),
        .ibuffer_pc_out            (ibuffer_pc_out),
        .fetch_inst                (fetch_inst),
        .fifo_empty                (fifo_empty)
    );

endmodule

// File: verif/ibuffer_tb.sv
`timescale 1ns/1ps
`include "ibuf_params.svh"

module ibuffer_tb;

    localparam int FW      = `IBUF_FETCH_WIDTH;
    localparam int TIMEOUT = 100;  // Cycles allowed for any single wait

    logic                               clock;
    logic                               reset_n;
    logic [`ICACHE_FETCHWIDTH128_RANGE] admin2ib_instr;
    logic [FW-1:0]                      admin2ib_instr_valid;
    ibuf_pkg::pc_t                      pc;
    logic [FW-1:0]                      admin2ib_predicttaken;
    logic [FW*32-1:0]                   admin2ib_predicttarget;
    logic                               fifo_read_en;
    logic                               mem_stall;
    logic                               redirect_valid;
    logic                               ibuffer_instr_valid;
    logic                               ibuffer_predicttaken_out;
    ibuf_pkg::target_t                  ibuffer_predicttarget_out;
    ibuf_pkg::instr_t                   ibuffer_inst_out;
    ibuf_pkg::ib_pc_t                   ibuffer_pc_out;
    logic                               fetch_inst;
    logic                               fifo_empty;

    integer seed = 32'h3bd1af51;

    // Expected decode entries, in read order
    ibuf_pkg::instr_t  exp_instr  [$];
    ibuf_pkg::ib_pc_t  exp_pc     [$];
    ibuf_pkg::target_t exp_target [$];
    logic              exp_taken  [$];

    ifu_ibuffer_top DUT (
        .clock                     (clock),
        .reset_n                   (reset_n),
        .admin2ib_instr            (admin2ib_instr),
        .admin2ib_instr_valid      (admin2ib_instr_valid),
        .pc                        (pc),
        .admin2ib_predicttaken     (admin2ib_predicttaken),
        .admin2ib_predicttarget    (admin2ib_predicttarget),
        .fifo_read_en              (fifo_read_en),
        .mem_stall                 (mem_stall),
        .redirect_valid            (redirect_valid),
        .ibuffer_instr_valid       (ibuffer_instr_valid),
        .ibuffer_predicttaken_out  (ibuffer_predicttaken_out),
        .ibuffer_predicttarget_out (ibuffer_predicttarget_out),
        .ibuffer_inst_out          (ibuffer_inst_out),
        .ibuffer_pc_out            (ibuffer_pc_out),
        .fetch_inst                (fetch_inst),
        .fifo_empty                (fifo_empty)
    );

    always #4 clock = ~clock;  // 8 ns period

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_instr(input ibuf_pkg::instr_t actual, input ibuf_pkg::instr_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s got %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_pc(input ibuf_pkg::ib_pc_t actual, input ibuf_pkg::ib_pc_t expected,
                            input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s got %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_target(input ibuf_pkg::target_t actual,
                                input ibuf_pkg::target_t expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s got %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s got %b, expected %b",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic wait_not_empty();
        bit found;
        found = 1'b0;
        for (int i = 0; i < TIMEOUT && !found; i++) begin
            @(negedge clock);
            found = !fifo_empty;
        end
        if (!found) begin
            $display("Timeout at time %0t: the FIFO never received an entry", $time);
            abort_run();
        end
    endtask

    task automatic wait_instr_valid();
        bit found;
        found = 1'b0;
        for (int i = 0; i < TIMEOUT && !found; i++) begin
            @(negedge clock);
            found = ibuffer_instr_valid;
        end
        if (!found) begin
            $display("Timeout at time %0t: no instruction reached decode", $time);
            abort_run();
        end
    endtask

    task automatic wait_fetch_request();
        bit found;
        found = 1'b0;
        for (int i = 0; i < TIMEOUT && !found; i++) begin
            @(negedge clock);
            found = fetch_inst;
        end
        if (!found) begin
            $display("Timeout at time %0t: fetch_inst never requested a bundle", $time);
            abort_run();
        end
    endtask

    function automatic int count_slots(input logic [FW-1:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < FW; i++) begin
            n = n + int'(mask[i]);
        end
        return n;
    endfunction

    // Random bundle whose valid slots go to the expected queues in slot order
    task automatic send_bundle(input logic [FW-1:0] mask, input ibuf_pkg::pc_t base);
        logic [FW*32-1:0] line;
        logic [FW*32-1:0] targets;
        logic [FW-1:0]    taken;
        logic [31:0]      rnd;
        ibuf_pkg::pc_t    slot_pc;
        for (int i = 0; i < FW; i++) begin
            rnd = $random(seed);
            line[i*32 +: 32] = rnd;
            rnd = $random(seed);
            targets[i*32 +: 32] = rnd;
            rnd = $random(seed);
            taken[i] = rnd[0];
            if (mask[i]) begin
                slot_pc = base + ibuf_pkg::pc_t'(4 * i);
                exp_instr.push_back(line[i*32 +: 32]);
                exp_pc.push_back(slot_pc[47:0]);  // Decode sees the low 48 bits
                exp_target.push_back(targets[i*32 +: 32]);
                exp_taken.push_back(taken[i]);
            end
        end
        @(posedge clock);
        admin2ib_instr         <= line;
        admin2ib_predicttarget <= targets;
        admin2ib_predicttaken  <= taken;
        pc                     <= base;
        admin2ib_instr_valid   <= mask;
        @(posedge clock);
        admin2ib_instr_valid <= '0;  // Mask is a one-cycle strobe
        // One slot lands per cycle after the bundle edge
        repeat (count_slots(mask)) @(posedge clock);
    endtask

    // Pop a single entry and compare every decode field
    task automatic read_and_check();
        ibuf_pkg::instr_t  e_instr;
        ibuf_pkg::ib_pc_t  e_pc;
        ibuf_pkg::target_t e_target;
        logic              e_taken;
        if (exp_instr.size() == 0) begin
            $display("Read at time %0t with no expected entry left", $time);
            abort_run();
        end
        e_instr  = exp_instr.pop_front();
        e_pc     = exp_pc.pop_front();
        e_target = exp_target.pop_front();
        e_taken  = exp_taken.pop_front();
        wait_not_empty();
        @(posedge clock);
        fifo_read_en <= 1'b1;
        @(posedge clock);
        fifo_read_en <= 1'b0;
        wait_instr_valid();
        check_instr(ibuffer_inst_out, e_instr, "instruction");
        check_pc(ibuffer_pc_out, e_pc, "PC");
        check_target(ibuffer_predicttarget_out, e_target, "predicted target");
        check_bit(ibuffer_predicttaken_out, e_taken, "predict-taken");
    endtask

    task automatic check_drained();
        check_bit(fifo_empty, 1'b1, "fifo_empty after all reads");
        if (exp_instr.size() != 0) begin
            $display("At time %0t %0d expected entries never reached decode",
                     $time, exp_instr.size());
            abort_run();
        end
    endtask

    task automatic test_reset_state();
        @(negedge clock);
        check_bit(fifo_empty, 1'b1, "fifo_empty after reset");
        check_bit(ibuffer_instr_valid, 1'b0, "instr valid after reset");
        check_bit(fetch_inst, 1'b1, "fetch_inst after reset");
    endtask

    task automatic test_full_bundle();
        wait_fetch_request();
        // Slot PCs carry across bit 47
        send_bundle(4'b1111, 64'hffff_7fff_ffff_fff8);
        for (int i = 0; i < FW; i++) begin
            read_and_check();
        end
        check_drained();
    endtask

    task automatic test_partial_bundles();
        for (int n = 1; n < FW; n++) begin
            wait_fetch_request();
            send_bundle(FW'((1 << n) - 1), 64'h0000_0000_8000_1000 + 64'(n) * 64'h100);
            for (int k = 0; k < n; k++) begin
                read_and_check();
            end
            check_drained();
        end
    endtask

    task automatic test_stall_full();
        ibuf_pkg::instr_t held_instr;
        ibuf_pkg::ib_pc_t held_pc;
        wait_fetch_request();
        send_bundle(4'b1111, 64'h0000_0000_0040_0000);
        send_bundle(4'b1111, 64'h0000_0000_0040_0010);  // Sent early to fill all 8 entries
        @(negedge clock);
        held_instr = ibuffer_inst_out;
        held_pc    = ibuffer_pc_out;
        check_bit(fifo_empty, 1'b0, "fifo_empty with 8 entries");
        @(posedge clock);
        mem_stall    <= 1'b1;
        fifo_read_en <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(negedge clock);
            check_bit(ibuffer_instr_valid, 1'b0, "instr valid during stall");
            check_instr(ibuffer_inst_out, held_instr, "instruction held in stall");
            check_pc(ibuffer_pc_out, held_pc, "PC held in stall");
            check_bit(fifo_empty, 1'b0, "fifo_empty during stall");
        end
        @(posedge clock);
        mem_stall    <= 1'b0;
        fifo_read_en <= 1'b0;
        for (int i = 0; i < 2 * FW; i++) begin
            read_and_check();
        end
        check_drained();
    endtask

    task automatic test_fetch_request();
        wait_fetch_request();
        send_bundle(4'b1111, 64'h0000_0001_0000_0100);
        @(negedge clock);
        check_bit(fetch_inst, 1'b0, "fetch_inst with 4 entries");
        read_and_check();      // Occupancy steps from 4 to 3
        wait_fetch_request();
        for (int i = 1; i < FW; i++) begin
            read_and_check();
        end
        check_drained();
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            check_bit(fetch_inst, 1'b1, "fetch_inst while FIFO empty");
        end
    endtask

    task automatic test_redirect();
        wait_fetch_request();
        send_bundle(4'b1111, 64'h0000_0000_2000_0000);
        @(posedge clock);
        redirect_valid <= 1'b1;
        fifo_read_en   <= 1'b1;  // Read collides with the flush
        @(posedge clock);
        redirect_valid <= 1'b0;
        // Flushed entries never reach decode
        exp_instr.delete();
        exp_pc.delete();
        exp_target.delete();
        exp_taken.delete();
        @(negedge clock);
        check_bit(fifo_empty, 1'b1, "fifo_empty after redirect");
        check_bit(fetch_inst, 1'b1, "fetch_inst after redirect");
        check_bit(ibuffer_instr_valid, 1'b0, "instr valid after redirect");
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            check_bit(ibuffer_instr_valid, 1'b0, "instr valid on read after flush");
            check_bit(fifo_empty, 1'b1, "fifo_empty on read after flush");
        end
        @(posedge clock);
        fifo_read_en <= 1'b0;
        wait_fetch_request();
        send_bundle(4'b1111, 64'h0000_0000_3000_0040);  // Redirect target bundle
        for (int i = 0; i < FW; i++) begin
            read_and_check();
        end
        check_drained();
    endtask

    initial begin
        clock                  = 1'b0;
        reset_n                = 1'b0;
        admin2ib_instr         = '0;
        admin2ib_instr_valid   = '0;
        pc                     = '0;
        admin2ib_predicttaken  = '0;
        admin2ib_predicttarget = '0;
        fifo_read_en           = 1'b0;
        mem_stall              = 1'b0;
        redirect_valid         = 1'b0;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;

        test_reset_state();
        test_full_bundle();
        test_partial_bundles();
        test_stall_full();
        test_fetch_request();
        test_redirect();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
verilog/ibuf_pkg.sv
verilog/fifo_ibuffer.sv
verilog/ibuffer.sv
verilog/ifu_ibuffer_top.sv
verif/ibuffer_tb.sv

// File: Makefile
# Verilator flow for the instruction buffer testbench
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= ibuffer_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# Result comes from the log, not from the simulator exit code
sim: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
